/* common/ic_pkg.sv */
/*
 * Interconnect shared definitions.
 * Bus widths, request/response payloads, target names and the default memory map.
 */
package ic_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------

    localparam int ADDR_W = 32;                 // Byte address
    localparam int DATA_W = 32;                 // One word per transfer
    localparam int STRB_W = DATA_W / 8;         // One strobe bit per byte

    // ------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------

    // Request payload, 69 bits
    typedef struct packed {
        logic              wen;                 // Write enable
        logic [STRB_W-1:0] strb;                // Byte strobes
        logic [DATA_W-1:0] wdata;               // Write data
        logic [ADDR_W-1:0] addr;                // Read/write address
    } mem_req_t;

    // Response payload, 33 bits
    typedef struct packed {
        logic              error;               // Bus error
        logic [DATA_W-1:0] rdata;               // Read data
    } mem_rsp_t;

    // Source of a response, as decoded from the request address
    typedef enum logic [1:0] {
        TGT_ROM = 2'd0,                         // ROM channel
        TGT_RAM = 2'd1,                         // RAM channel
        TGT_ERR = 2'd2                          // Local error responder
    } target_e;

    // ------------------------------------------------------------
    // Default memory map
    // ------------------------------------------------------------

    localparam logic [ADDR_W-1:0] MAP_ROM_MATCH_DEF = 32'h1000_0000; // 16 KiB window
    localparam logic [ADDR_W-1:0] MAP_ROM_MASK_DEF  = 32'hFFFF_C000;
    localparam logic [ADDR_W-1:0] MAP_RAM_MATCH_DEF = 32'h2000_0000; // 64 KiB window
    localparam logic [ADDR_W-1:0] MAP_RAM_MASK_DEF  = 32'hFFFF_0000;

endpackage

/* source/ic_addr_decode.sv */
/*
 * Address decoder.
 * Match/mask lookup of a request address into ROM, RAM or the error responder.
 */
`timescale 1ns/1ps

module ic_addr_decode #(
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MATCH = ic_pkg::MAP_ROM_MATCH_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MASK  = ic_pkg::MAP_ROM_MASK_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MATCH = ic_pkg::MAP_RAM_MATCH_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MASK  = ic_pkg::MAP_RAM_MASK_DEF
) (
    input  logic [ic_pkg::ADDR_W-1:0] addr,     // Request address
    output ic_pkg::target_e           target    // Decoded destination
);
    import ic_pkg::*;

    logic rom_hit;                              // Address inside ROM window
    logic ram_hit;                              // Address inside RAM window

    assign rom_hit = (addr & MAP_ROM_MASK) == MAP_ROM_MATCH;
    assign ram_hit = (addr & MAP_RAM_MASK) == MAP_RAM_MATCH;

    // ROM wins if the two windows ever overlap
    always_comb begin
        if (rom_hit) begin
            target = TGT_ROM;
        end else if (ram_hit) begin
            target = TGT_RAM;
        end else begin
            target = TGT_ERR;                   // Unmapped, former AXI window too
        end
    end

endmodule

/* source/ic_error_rsp.sv */
/*
 * Error responder.
 * Stands in for a target at unmapped addresses and answers each request
 * with an error one cycle after the grant.
 */
`timescale 1ns/1ps

module ic_error_rsp (
    input  logic             g_clk,
    input  logic             rst,
    input  logic             req,               // Request from the router
    input  logic             ack,               // Response taken by the CPU
    output logic             gnt,               // Request accepted
    output logic             recv,              // Response valid
    output ic_pkg::mem_rsp_t rsp                // Response payload
);

    logic busy;                                 // One request held

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------

    assign gnt  = !busy;                        // Idle means ready
    assign recv = busy;                         // Held until ack

    always_comb begin
        rsp.error = busy;                       // Error flagged with recv
        rsp.rdata = '0;                         // Never any read data
    end

    // ------------------------------------------------------------
    // Busy flag
    // ------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (req && gnt) begin
            busy <= 1'b1;                       // Respond next cycle
        end else if (busy && ack) begin
            busy <= 1'b0;                       // Response taken
        end
    end

endmodule

/* source/ic_rsp_tracker.sv */
/*
 * Response tracker.
 * In-order queue holding the target of each outstanding request.
 * The head names the source allowed to answer, full stops new grants.
 */
`timescale 1ns/1ps

module ic_rsp_tracker #(
    parameter int MAX_OUTSTANDING = 3
) (
    input  logic            g_clk,
    input  logic            rst,
    input  logic            push,               // Request accepted
    input  ic_pkg::target_e push_target,        // Its decoded target
    input  logic            pop,                // Response accepted
    output ic_pkg::target_e head_target,        // Oldest outstanding target
    output logic            head_valid,         // Queue not empty
    output logic            full                // No room for another request
);
    import ic_pkg::*;

    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(MAX_OUTSTANDING - 1);

    target_e          queue [MAX_OUTSTANDING];  // Target per slot
    logic [PTR_W-1:0] wr_ptr;                   // Next free slot
    logic [PTR_W-1:0] rd_ptr;                   // Head slot
    logic [CNT_W-1:0] count;                    // Entries in use

    // Wraps at the queue depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_IDX) ? '0 : ptr + PTR_W'(1);
    endfunction

    // ------------------------------------------------------------
    // Status
    // ------------------------------------------------------------

    assign head_target = queue[rd_ptr];
    assign head_valid  = count != '0;
    assign full        = count == CNT_W'(MAX_OUTSTANDING);

    // ------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // Slot storage
    always_ff @(posedge g_clk) begin
        if (push) begin
            queue[wr_ptr] <= push_target;
        end
    end

endmodule

/* port_router/ic_port_router.sv */
/*
 * Port router for one CPU memory port.
 * Decodes each request onto the ROM, RAM or error channel, tracks the
 * outstanding targets and steers the responses back in request order.
 */
`timescale 1ns/1ps

module ic_port_router #(
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MATCH   = ic_pkg::MAP_ROM_MATCH_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MASK    = ic_pkg::MAP_ROM_MASK_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MATCH   = ic_pkg::MAP_RAM_MATCH_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MASK    = ic_pkg::MAP_RAM_MASK_DEF,
    parameter int                        MAX_OUTSTANDING = 3
) (
    input  logic             g_clk,
    input  logic             rst,
    // CPU side
    input  logic             req,               // CPU request
    input  ic_pkg::mem_req_t req_data,          // CPU request payload
    output logic             gnt,               // Request accepted
    output logic             recv,              // Response valid
    output ic_pkg::mem_rsp_t rsp,               // Response payload
    input  logic             ack,               // Response taken
    // Target side
    output logic             rom_req,
    output logic             ram_req,
    output ic_pkg::mem_req_t tgt_req_data,      // Shared by both targets
    input  logic             rom_gnt,
    input  logic             ram_gnt,
    input  logic             rom_recv,
    input  logic             ram_recv,
    input  ic_pkg::mem_rsp_t rom_rsp,
    input  ic_pkg::mem_rsp_t ram_rsp,
    output logic             rom_ack,
    output logic             ram_ack
);
    import ic_pkg::*;

    target_e  req_target;                       // Decoded from the address
    target_e  head_target;                      // Oldest outstanding target
    logic     head_valid;
    logic     full;                             // Tracker out of room
    logic     err_req;
    logic     err_gnt;
    logic     err_recv;
    logic     err_ack;
    mem_rsp_t err_rsp;
    logic     sel_rom;                          // Head source is the ROM
    logic     sel_ram;
    logic     sel_err;

    // ------------------------------------------------------------
    // Request fan-out
    // ------------------------------------------------------------

    ic_addr_decode #(
        .MAP_ROM_MATCH (MAP_ROM_MATCH),
        .MAP_ROM_MASK  (MAP_ROM_MASK),
        .MAP_RAM_MATCH (MAP_RAM_MATCH),
        .MAP_RAM_MASK  (MAP_RAM_MASK)
    ) u_decode (
        .addr   (req_data.addr),
        .target (req_target)
    );

    // Forward only while the tracker can take the entry
    assign rom_req = req && !full && (req_target == TGT_ROM);
    assign ram_req = req && !full && (req_target == TGT_RAM);
    assign err_req = req && !full && (req_target == TGT_ERR);

    assign tgt_req_data = req_data;             // Payload unchanged

    // Selected target's grant only
    assign gnt = (rom_req && rom_gnt) || (ram_req && ram_gnt) || (err_req && err_gnt);

    ic_error_rsp u_err (
        .g_clk (g_clk),
        .rst   (rst),
        .req   (err_req),
        .ack   (err_ack),
        .gnt   (err_gnt),
        .recv  (err_recv),
        .rsp   (err_rsp)
    );

    // ------------------------------------------------------------
    // Response ordering
    // ------------------------------------------------------------

    ic_rsp_tracker #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_tracker (
        .g_clk       (g_clk),
        .rst         (rst),
        .push        (gnt),                     // Every accepted request
        .push_target (req_target),
        .pop         (recv && ack),             // Every accepted response
        .head_target (head_target),
        .head_valid  (head_valid),
        .full        (full)
    );

    assign sel_rom = head_valid && (head_target == TGT_ROM);
    assign sel_ram = head_valid && (head_target == TGT_RAM);
    assign sel_err = head_valid && (head_target == TGT_ERR);

    assign recv = (sel_rom && rom_recv) || (sel_ram && ram_recv) || (sel_err && err_recv);

    always_comb begin
        rsp = '0;                               // Quiet with nothing outstanding
        if (sel_rom) rsp = rom_rsp;
        if (sel_ram) rsp = ram_rsp;
        if (sel_err) rsp = err_rsp;
    end

    // Ack only to the head source, others keep waiting
    assign rom_ack = sel_rom && ack;
    assign ram_ack = sel_ram && ack;
    assign err_ack = sel_err && ack;

endmodule

/* source/ic_top.sv */
/*
 * Memory interconnect top.
 * One router per CPU port, each with its own ROM and RAM channel.
 */
`timescale 1ns/1ps

module ic_top #(
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MATCH   = ic_pkg::MAP_ROM_MATCH_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MASK    = ic_pkg::MAP_ROM_MASK_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MATCH   = ic_pkg::MAP_RAM_MATCH_DEF,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MASK    = ic_pkg::MAP_RAM_MASK_DEF,
    parameter int                        MAX_OUTSTANDING = 3
) (
    input  logic             g_clk,
    input  logic             rst,
    // CPU instruction port
    input  logic             imem_req,
    input  ic_pkg::mem_req_t imem_req_data,
    output logic             imem_gnt,
    output logic             imem_recv,
    output ic_pkg::mem_rsp_t imem_rsp,
    input  logic             imem_ack,
    // CPU data port
    input  logic             dmem_req,
    input  ic_pkg::mem_req_t dmem_req_data,
    output logic             dmem_gnt,
    output logic             dmem_recv,
    output ic_pkg::mem_rsp_t dmem_rsp,
    input  logic             dmem_ack,
    // ROM, instruction side
    output logic             rom_imem_req,
    output ic_pkg::mem_req_t rom_imem_req_data,
    input  logic             rom_imem_gnt,
    input  logic             rom_imem_recv,
    input  ic_pkg::mem_rsp_t rom_imem_rsp,
    output logic             rom_imem_ack,
    // RAM, instruction side
    output logic             ram_imem_req,
    output ic_pkg::mem_req_t ram_imem_req_data,
    input  logic             ram_imem_gnt,
    input  logic             ram_imem_recv,
    input  ic_pkg::mem_rsp_t ram_imem_rsp,
    output logic             ram_imem_ack,
    // ROM, data side
    output logic             rom_dmem_req,
    output ic_pkg::mem_req_t rom_dmem_req_data,
    input  logic             rom_dmem_gnt,
    input  logic             rom_dmem_recv,
    input  ic_pkg::mem_rsp_t rom_dmem_rsp,
    output logic             rom_dmem_ack,
    // RAM, data side
    output logic             ram_dmem_req,
    output ic_pkg::mem_req_t ram_dmem_req_data,
    input  logic             ram_dmem_gnt,
    input  logic             ram_dmem_recv,
    input  ic_pkg::mem_rsp_t ram_dmem_rsp,
    output logic             ram_dmem_ack
);
    import ic_pkg::*;

    mem_req_t imem_tgt_req_data;                // Fanned out to both channels
    mem_req_t dmem_tgt_req_data;

    assign rom_imem_req_data = imem_tgt_req_data;
    assign ram_imem_req_data = imem_tgt_req_data;
    assign rom_dmem_req_data = dmem_tgt_req_data;
    assign ram_dmem_req_data = dmem_tgt_req_data;

    // ------------------------------------------------------------
    // Instruction port
    // ------------------------------------------------------------

    ic_port_router #(
        .MAP_ROM_MATCH   (MAP_ROM_MATCH),
        .MAP_ROM_MASK    (MAP_ROM_MASK),
        .MAP_RAM_MATCH   (MAP_RAM_MATCH),
        .MAP_RAM_MASK    (MAP_RAM_MASK),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_imem (
        .g_clk        (g_clk),
        .rst          (rst),
        .req          (imem_req),
        .req_data     (imem_req_data),
        .gnt          (imem_gnt),
        .recv         (imem_recv),
        .rsp          (imem_rsp),
        .ack          (imem_ack),
        .rom_req      (rom_imem_req),
        .ram_req      (ram_imem_req),
        .tgt_req_data (imem_tgt_req_data),
        .rom_gnt      (rom_imem_gnt),
        .ram_gnt      (ram_imem_gnt),
        .rom_recv     (rom_imem_recv),
        .ram_recv     (ram_imem_recv),
        .rom_rsp      (rom_imem_rsp),
        .ram_rsp      (ram_imem_rsp),
        .rom_ack      (rom_imem_ack),
        .ram_ack      (ram_imem_ack)
    );

    // ------------------------------------------------------------
    // Data port
    // ------------------------------------------------------------

    ic_port_router #(
        .MAP_ROM_MATCH   (MAP_ROM_MATCH),
        .MAP_ROM_MASK    (MAP_ROM_MASK),
        .MAP_RAM_MATCH   (MAP_RAM_MATCH),
        .MAP_RAM_MASK    (MAP_RAM_MASK),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_dmem (
        .g_clk        (g_clk),
        .rst          (rst),
        .req          (dmem_req),
        .req_data     (dmem_req_data),
        .gnt          (dmem_gnt),
        .recv         (dmem_recv),
        .rsp          (dmem_rsp),
        .ack          (dmem_ack),
        .rom_req      (rom_dmem_req),
        .ram_req      (ram_dmem_req),
        .tgt_req_data (dmem_tgt_req_data),
        .rom_gnt      (rom_dmem_gnt),
        .ram_gnt      (ram_dmem_gnt),
        .rom_recv     (rom_dmem_recv),
        .ram_recv     (ram_dmem_recv),
        .rom_rsp      (rom_dmem_rsp),
        .ram_rsp      (ram_dmem_rsp),
        .rom_ack      (rom_dmem_ack),
        .ram_ack      (ram_dmem_ack)
    );

endmodule

/* dv/tb_ic_top.sv */
/*
 * Testbench for the memory interconnect.
 * Replays transactions from a vector file on both CPU ports against ROM/RAM
 * target models with random grant and response delay, and checks routing and order.
 */
`timescale 1ns/1ps

module tb_ic_top;
    import ic_pkg::*;

    localparam int          MAX_OUT    = 3;
    localparam int          VEC_MAX    = 64;
    localparam int          RAM_WORDS  = 256;          // Low 1 KiB of the RAM window
    localparam int          PEND_DEPTH = 8;
    localparam logic [31:0] RNG_SEED   = 32'h2e888002;

    // One vector line, 30 hex digits
    typedef struct packed {
        logic [3:0]  port;                             // 0 imem, 1 dmem
        logic [31:0] addr;
        logic [3:0]  wen;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [7:0]  hold;                             // Cycles with ack held low
        logic [3:0]  err;                              // Expected error flag
        logic [31:0] rdata;                            // Expected read data
    } vec_t;

    logic     g_clk = 1'b0;
    logic     rst   = 1'b1;
    logic     rst_d = 1'b0;
    // CPU side, index 0 imem and 1 dmem
    logic     cpu_req      [2] = '{default: 1'b0};
    mem_req_t cpu_req_data [2] = '{default: '0};
    logic     cpu_ack      [2] = '{default: 1'b0};
    logic     cpu_gnt      [2];
    logic     cpu_recv     [2];
    mem_rsp_t cpu_rsp      [2];
    // Target side, 0 rom_imem, 1 ram_imem, 2 rom_dmem, 3 ram_dmem
    logic     ch_gnt      [4] = '{default: 1'b0};
    logic     ch_recv     [4] = '{default: 1'b0};
    mem_rsp_t ch_rsp      [4] = '{default: '0};
    logic     ch_req      [4];
    mem_req_t ch_req_data [4];
    logic     ch_ack      [4];

    logic [119:0] vec_mem [VEC_MAX];
    logic [31:0]  ram_mem [RAM_WORDS];                 // Both RAM channels share it
    mem_rsp_t     pend_rsp [4][PEND_DEPTH];            // Accepted, not yet answered
    int           pend_due [4][PEND_DEPTH];
    int           pend_rd  [4];
    int           pend_cnt [4];
    target_e      order_q [2][$];                      // Targets still owing a response
    int           num_vec      = 0;
    int           errors       = 0;
    int           stall_cycles = 0;
    int           cycle_cnt    = 0;
    int           cycle_limit  = 100000;

    ic_top #(.MAX_OUTSTANDING(MAX_OUT)) i_dut (
        .g_clk(g_clk), .rst(rst),
        .imem_req(cpu_req[0]), .imem_req_data(cpu_req_data[0]), .imem_gnt(cpu_gnt[0]),
        .imem_recv(cpu_recv[0]), .imem_rsp(cpu_rsp[0]), .imem_ack(cpu_ack[0]),
        .dmem_req(cpu_req[1]), .dmem_req_data(cpu_req_data[1]), .dmem_gnt(cpu_gnt[1]),
        .dmem_recv(cpu_recv[1]), .dmem_rsp(cpu_rsp[1]), .dmem_ack(cpu_ack[1]),
        .rom_imem_req(ch_req[0]), .rom_imem_req_data(ch_req_data[0]), .rom_imem_gnt(ch_gnt[0]),
        .rom_imem_recv(ch_recv[0]), .rom_imem_rsp(ch_rsp[0]), .rom_imem_ack(ch_ack[0]),
        .ram_imem_req(ch_req[1]), .ram_imem_req_data(ch_req_data[1]), .ram_imem_gnt(ch_gnt[1]),
        .ram_imem_recv(ch_recv[1]), .ram_imem_rsp(ch_rsp[1]), .ram_imem_ack(ch_ack[1]),
        .rom_dmem_req(ch_req[2]), .rom_dmem_req_data(ch_req_data[2]), .rom_dmem_gnt(ch_gnt[2]),
        .rom_dmem_recv(ch_recv[2]), .rom_dmem_rsp(ch_rsp[2]), .rom_dmem_ack(ch_ack[2]),
        .ram_dmem_req(ch_req[3]), .ram_dmem_req_data(ch_req_data[3]), .ram_dmem_gnt(ch_gnt[3]),
        .ram_dmem_recv(ch_recv[3]), .ram_dmem_rsp(ch_rsp[3]), .ram_dmem_ack(ch_ack[3])
    );

    always #5 g_clk = ~g_clk;                          // 10 ns period

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Memory map rule, default windows
    function automatic target_e decode_target(input logic [ADDR_W-1:0] addr);
        if ((addr & MAP_ROM_MASK_DEF) == MAP_ROM_MATCH_DEF) return TGT_ROM;
        if ((addr & MAP_RAM_MASK_DEF) == MAP_RAM_MATCH_DEF) return TGT_RAM;
        return TGT_ERR;
    endfunction

    // ------------------------------------------------------------
    // Target models
    // ------------------------------------------------------------

    always @(posedge g_clk) begin
        int       c;
        int       b;
        int       slot;
        int       head;
        logic [7:0] idx;
        mem_rsp_t rsp_val;
        for (c = 0; c < 4; c++) begin
            if (rst) begin
                ch_gnt[c]   <= 1'b0;
                ch_recv[c]  <= 1'b0;
                ch_rsp[c]   <= '0;
                pend_rd[c]  = 0;
                pend_cnt[c] = 0;
            end else begin
                if (ch_recv[c] && ch_ack[c]) begin     // Head taken
                    pend_rd[c]  = (pend_rd[c] + 1) % PEND_DEPTH;
                    pend_cnt[c] = pend_cnt[c] - 1;
                end
                if (ch_req[c] && ch_gnt[c]) begin
                    rsp_val = '0;
                    idx     = ch_req_data[c].addr[9:2];
                    if ((c % 2) == 0) begin
                        rsp_val.rdata = ~ch_req_data[c].addr;  // ROM ignores writes
                    end else if (ch_req_data[c].wen) begin
                        for (b = 0; b < STRB_W; b++) begin
                            if (ch_req_data[c].strb[b]) begin
                                ram_mem[idx][8*b +: 8] = ch_req_data[c].wdata[8*b +: 8];
                            end
                        end
                    end else begin
                        rsp_val.rdata = ram_mem[idx];
                    end
                    slot                = (pend_rd[c] + pend_cnt[c]) % PEND_DEPTH;
                    pend_rsp[c][slot]   = rsp_val;
                    pend_due[c][slot]   = cycle_cnt + 1 + int'($urandom % 3);  // 1 to 3 cycles
                    pend_cnt[c]         = pend_cnt[c] + 1;
                end
                head = pend_rd[c];
                ch_recv[c] <= (pend_cnt[c] > 0) && (pend_due[c][head] <= cycle_cnt);
                ch_rsp[c]  <= (pend_cnt[c] > 0) ? pend_rsp[c][head] : '0;
                ch_gnt[c]  <= ($urandom % 4) != 0;     // Grant three cycles in four
            end
        end
        if (rst) begin
            for (c = 0; c < RAM_WORDS; c++) begin
                ram_mem[c] = (MAP_RAM_MATCH_DEF | (32'(c) << 2)) ^ 32'hA5A5_A5A5;
            end
        end
    end

    // ------------------------------------------------------------
    // Routing, reset and full-stall monitor
    // ------------------------------------------------------------

    always @(posedge g_clk) begin
        int      p;
        target_e tgt;
        target_e head;
        logic    room;
        logic    pending;
        for (p = 0; p < 2; p++) begin
            if (rst_d) begin                           // During and right after reset
                check_eq(128'(cpu_gnt[p]), '0, $sformatf("port %0d gnt in reset", p));
                check_eq(128'(cpu_recv[p]), '0, $sformatf("port %0d recv in reset", p));
                check_eq(128'(ch_req[2*p]), '0, $sformatf("port %0d ROM req in reset", p));
                check_eq(128'(ch_req[2*p+1]), '0, $sformatf("port %0d RAM req in reset", p));
                order_q[p].delete();
            end else if (!rst) begin
                tgt     = decode_target(cpu_req_data[p].addr);
                room    = order_q[p].size() < MAX_OUT;
                pending = order_q[p].size() > 0;
                head    = pending ? order_q[p][0] : TGT_ERR;
                check_eq(128'(ch_req[2*p]), 128'(cpu_req[p] && room && tgt == TGT_ROM),
                         $sformatf("port %0d ROM req", p));
                check_eq(128'(ch_req[2*p+1]), 128'(cpu_req[p] && room && tgt == TGT_RAM),
                         $sformatf("port %0d RAM req", p));
                if (cpu_req[p] && room && tgt != TGT_ERR) begin
                    check_eq(128'(ch_req_data[2*p + int'(tgt == TGT_RAM)]),
                             128'(cpu_req_data[p]), $sformatf("port %0d payload", p));
                end
                // Ack reaches only the oldest outstanding target
                check_eq(128'(ch_ack[2*p]), 128'(cpu_ack[p] && pending && head == TGT_ROM),
                         $sformatf("port %0d ROM ack", p));
                check_eq(128'(ch_ack[2*p+1]), 128'(cpu_ack[p] && pending && head == TGT_RAM),
                         $sformatf("port %0d RAM ack", p));
                if (!room) begin
                    check_eq(128'(cpu_gnt[p]), '0, $sformatf("port %0d gnt while full", p));
                    if (cpu_req[p]) begin
                        stall_cycles++;
                    end
                end
                if (cpu_req[p] && cpu_gnt[p]) begin
                    order_q[p].push_back(tgt);
                end
                if (cpu_recv[p] && cpu_ack[p]) begin
                    void'(order_q[p].pop_front());
                end
            end
        end
        rst_d <= rst;
    end

    always @(posedge g_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // CPU side driver and response collection
    // ------------------------------------------------------------

    // Requests go out in file order, one at a time over both ports
    task automatic drive_requests();
        int   i;
        int   p;
        vec_t v;
        for (i = 0; i < num_vec; i++) begin
            v = vec_t'(vec_mem[i]);
            p = int'(v.port[0]);
            cpu_req[p]      <= 1'b1;
            cpu_req_data[p] <= '{wen: v.wen[0], strb: v.strb, wdata: v.wdata, addr: v.addr};
            @(posedge g_clk);
            while (!cpu_gnt[p]) @(posedge g_clk);
            cpu_req[p] <= 1'b0;
        end
    endtask

    task automatic collect_responses(input int p);
        int       i;
        int       k;
        vec_t     v;
        mem_rsp_t held;
        for (i = 0; i < num_vec; i++) begin
            v = vec_t'(vec_mem[i]);
            if (int'(v.port[0]) == p) begin
                @(posedge g_clk);
                while (!cpu_recv[p]) @(posedge g_clk);
                held = cpu_rsp[p];
                check_eq(128'(held), 128'({v.err[0], v.rdata}), $sformatf("vector %0d rsp", i));
                for (k = 0; k < int'(v.hold); k++) begin
                    @(posedge g_clk);
                    check_eq(128'(cpu_recv[p]), 128'(1), $sformatf("vector %0d recv held", i));
                    check_eq(128'(cpu_rsp[p]), 128'(held), $sformatf("vector %0d rsp held", i));
                end
                cpu_ack[p] <= 1'b1;
                @(posedge g_clk);                      // Transfer edge
                check_eq(128'(cpu_recv[p]), 128'(1), $sformatf("vector %0d recv at ack", i));
                cpu_ack[p] <= 1'b0;
            end
        end
    endtask

    initial begin
        int i;
        void'($urandom(RNG_SEED));
        for (i = 0; i < VEC_MAX; i++) begin
            vec_mem[i] = '1;                           // Port F marks the end
        end
        $readmemh("dv/ic_vectors.txt", vec_mem);
        while (num_vec < VEC_MAX && vec_mem[num_vec][119:116] != 4'hF) num_vec++;
        cycle_limit = 200 * num_vec + 16;
        repeat (16) @(posedge g_clk);
        rst <= 1'b0;
        @(posedge g_clk);
        fork
            drive_requests();
            collect_responses(0);
            collect_responses(1);
        join
        repeat (2) @(posedge g_clk);
        if (num_vec == 0) begin
            $display("No vectors were read from dv/ic_vectors.txt");
            errors++;
        end
        if (stall_cycles == 0) begin
            $display("The tracker never filled up, so the full stall was not exercised");
            errors++;
        end
        $display("Done: %0d vectors, %0d stall cycles, %0d errors", num_vec, stall_cycles, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* dv/ic_vectors.txt */
// port_addr_wen_strb_wdata_hold_experr_exprdata, port 0 imem and 1 dmem
// ROM reads return the inverted address, RAM starts as address ^ A5A5A5A5
0_10000000_0_F_00000000_00_0_EFFFFFFF
1_10000004_0_F_00000000_00_0_EFFFFFFB
1_10003FFC_0_F_00000000_01_0_EFFFC003
1_20000000_0_F_00000000_00_0_85A5A5A5
// Strobed RAM writes, read back on both ports
1_20000010_1_5_11223344_00_0_00000000
1_20000010_0_F_00000000_00_0_8522A544
0_20000010_0_F_00000000_00_0_8522A544
1_20000020_1_F_CAFEF00D_00_0_00000000
1_20000020_1_8_99000000_00_0_00000000
1_20000020_0_F_00000000_02_0_99FEF00D
0_20000020_0_F_00000000_00_0_99FEF00D
// ROM write is ignored
1_10000008_1_F_DEADBEEF_00_0_EFFFFFF7
1_10000008_0_F_00000000_00_0_EFFFFFF7
// Unmapped addresses answer with an error
1_40000000_0_F_00000000_00_1_00000000
0_10004000_0_F_00000000_03_1_00000000
1_20010000_1_F_12345678_00_1_00000000
// Long hold on the first response fills the tracker
1_10000010_0_F_00000000_14_0_EFFFFFEF
1_20000020_0_F_00000000_00_0_99FEF00D
1_40000000_0_F_00000000_00_1_00000000
1_10000040_0_F_00000000_00_0_EFFFFFBF
1_20000030_0_F_00000000_00_0_85A5A595
0_20000100_0_F_00000000_10_0_85A5A4A5
0_00000000_0_F_00000000_00_1_00000000
0_1000000C_0_F_00000000_00_0_EFFFFFF3
0_20000004_0_F_00000000_00_0_85A5A5A1

/* build.f */
common/ic_pkg.sv
source/ic_addr_decode.sv
source/ic_error_rsp.sv
source/ic_rsp_tracker.sv
port_router/ic_port_router.sv
source/ic_top.sv
dv/tb_ic_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the interconnect testbench with Verilator.
# Exits non-zero unless the run prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_ic_top -Mdir obj_dir -f build.f \
    && ./obj_dir/Vtb_ic_top | tee /dev/stderr | grep -qxF '** PASS **' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
